//--- hw/ddr_phy_cfg_pkg.sv
package ddr_phy_cfg_pkg;

  // capture offset select in each lane
  localparam int SLIP_W = 2;

  // one FCLK sample per offset
  localparam int SLIP_POS = 1 << SLIP_W;

  // bits per lane per PCLK
  localparam int SYMS_PER_BEAT = 2;

  // beats in one training pass
  localparam int TRAIN_LEN = 4;

  // beat 0 sits in the low slice: 10, 01, 11, 00
  localparam logic [TRAIN_LEN-1:0][SYMS_PER_BEAT-1:0] TRAIN_PATTERN = {
    2'b00,
    2'b11,
    2'b01,
    2'b10
  };

endpackage

//--- hw/ddr_phy_ctl_pkg.sv
package ddr_phy_ctl_pkg;

  // training and service sequence of the controller
  typedef enum logic [2:0] {
    ST_IDLE_RESET  = 3'd0,  // also parks here when training gives up
    ST_TRAIN_WR    = 3'd1,
    ST_TRAIN_RD    = 3'd2,
    ST_TRAIN_CHECK = 3'd3,
    ST_SLIP        = 3'd4,
    ST_READY       = 3'd5
  } ctl_state_t;

  // which way a beat moves across the pads
  typedef enum logic {
    BEAT_WR = 1'b0,  // user beat, pads driven
    BEAT_RD = 1'b1   // pattern beat that is read back, or pads released
  } beat_dir_t;

endpackage

//--- hw/ddr_lane_iob.sv
`timescale 1ns/1ps

module ddr_lane_iob (
  input  logic                                      PCLK,
  input  logic                                      FCLK,
  input  logic                                      RESET,
  input  logic                                      oe_n,
  input  logic [ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] tx_beat,
  input  logic                                      slip_pulse,
  output logic [ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] rx_beat,
  inout  wire                                       pad
);

  import ddr_phy_cfg_pkg::*;
  import ddr_phy_ctl_pkg::*;

  logic [SYMS_PER_BEAT-1:0] tx_q;
  beat_dir_t                dir_q;
  logic                     tgl_q;   // flips every PCLK
  logic                     tgl_f;   // tgl_q as seen one FCLK later
  logic                     pad_d;
  logic                     sym1_q;
  logic                     drv_q;
  logic [SLIP_POS-1:0]      hist;    // newest sample in bit 0
  logic                     tail_q;
  logic [SLIP_POS:0]        span;
  logic [SLIP_W-1:0]        slip_q;
  logic [SYMS_PER_BEAT-1:0] sel_q;

  always_ff @(posedge PCLK or posedge RESET) begin
    if (RESET) begin
      dir_q <= BEAT_RD;
      tgl_q <= 1'b0;
    end else begin
      dir_q <= oe_n ? BEAT_RD : BEAT_WR;
      tgl_q <= ~tgl_q;
    end
  end

  always_ff @(posedge PCLK) begin
    tx_q <= tx_beat;
  end

  // equal toggles mark the FCLK edge that lines up with PCLK
  always_ff @(posedge FCLK or posedge RESET) begin
    if (RESET) begin
      tgl_f <= 1'b0;
      drv_q <= 1'b0;
    end else begin
      tgl_f <= tgl_q;
      if (tgl_f == tgl_q) begin
        drv_q <= (dir_q == BEAT_WR);
      end
    end
  end

  always_ff @(posedge FCLK) begin
    if (tgl_f == tgl_q) begin
      pad_d  <= tx_q[0];  // symbol 0 goes out first
      sym1_q <= tx_q[1];
    end else begin
      pad_d <= sym1_q;
    end
    hist <= {hist[SLIP_POS-2:0], pad};
  end

  assign pad = drv_q ? pad_d : 1'bz;

  always_ff @(posedge PCLK or posedge RESET) begin
    if (RESET) begin
      slip_q <= '0;
    end else if (slip_pulse) begin
      slip_q <= slip_q + 1'b1;  // wraps over the four offsets
    end
  end

  // two FCLK samples later this one is the fifth newest
  assign span = {tail_q, hist};

  always_ff @(posedge PCLK) begin
    tail_q   <= hist[SLIP_POS-SYMS_PER_BEAT];
    sel_q[0] <= span[{1'b0, slip_q} + 3'd1];  // older sample is symbol 0
    sel_q[1] <= span[slip_q];
    rx_beat  <= sel_q;
  end

endmodule

//--- hw/ddr_rd_align.sv
`timescale 1ns/1ps

module ddr_rd_align #(
  parameter int LANES = 4
) (
  input  logic                                            PCLK,
  input  logic                                            RESET,
  input  logic                                            capture_stb,
  input  logic [LANES*ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] rx_beat,
  input  logic [ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0]       expect_beat,
  output logic [LANES*ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] rd_data,
  output logic [LANES-1:0]                                lane_match
);

  import ddr_phy_cfg_pkg::*;

  logic [LANES*SYMS_PER_BEAT-1:0] word_q;
  logic [LANES-1:0]               hit;
  logic [LANES-1:0]               match_q;

  for (genvar i = 0; i < LANES; i++) begin : g_cmp
    assign hit[i] = (rx_beat[i*SYMS_PER_BEAT +: SYMS_PER_BEAT] == expect_beat);
  end

  always_ff @(posedge PCLK) begin
    if (capture_stb) begin
      word_q <= rx_beat;
    end
  end

  // flags stay put until the next capture
  always_ff @(posedge PCLK or posedge RESET) begin
    if (RESET) begin
      match_q <= '0;
    end else if (capture_stb) begin
      match_q <= hit;
    end
  end

  assign rd_data    = word_q;
  assign lane_match = match_q;

endmodule

//--- hw/ddr_train_ctrl.sv
`timescale 1ns/1ps

module ddr_train_ctrl #(
  parameter int LANES  = 4,
  parameter int RD_LAT = 6
) (
  input  logic                                      PCLK,
  input  logic                                      RESET,
  input  logic                                      wr_stb,
  input  logic                                      rd_stb,
  input  logic [LANES-1:0]                          lane_match,
  output logic                                      oe_n,
  output ddr_phy_ctl_pkg::beat_dir_t                tx_sel,
  output logic [ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] pattern_beat,
  output logic [ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] expect_beat,
  output logic                                      capture_stb,
  output logic [LANES-1:0]                          slip_pulse,
  output logic                                      rd_valid,
  output logic                                      train_done
);

  import ddr_phy_cfg_pkg::*;
  import ddr_phy_ctl_pkg::*;

  localparam int CNT_W = $clog2(RD_LAT + 1);
  localparam int IDX_W = $clog2(TRAIN_LEN);

  ctl_state_t        state_q;
  logic [IDX_W-1:0]  beat_q;
  logic [CNT_W-1:0]  lat_q;      // cycles left to the capture point
  logic [LANES-1:0]  fail_q;     // lanes that missed any beat this pass
  logic [LANES-1:0]  fail_now;
  logic [SLIP_W-1:0] try_q;
  logic              stuck_q;
  logic              rd_busy_q;
  logic              rd_valid_q;
  logic              wr_ok;
  logic              rd_ok;

  assign wr_ok    = (state_q == ST_READY) && wr_stb && !rd_busy_q;
  assign rd_ok    = (state_q == ST_READY) && rd_stb && !rd_busy_q;
  assign fail_now = fail_q | ~lane_match;

  assign oe_n         = !((state_q == ST_TRAIN_WR) || wr_ok);
  assign tx_sel       = (state_q == ST_READY) ? BEAT_WR : BEAT_RD;
  assign pattern_beat = TRAIN_PATTERN[beat_q];
  assign expect_beat  = TRAIN_PATTERN[beat_q];  // one beat per pass step
  assign capture_stb  = (lat_q == CNT_W'(1)) && ((state_q == ST_TRAIN_RD) || rd_busy_q);
  assign slip_pulse   = (state_q == ST_SLIP) ? fail_q : '0;
  assign rd_valid     = rd_valid_q;
  assign train_done   = (state_q == ST_READY);

  always_ff @(posedge PCLK or posedge RESET) begin
    if (RESET) begin
      state_q    <= ST_IDLE_RESET;
      beat_q     <= '0;
      lat_q      <= '0;
      fail_q     <= '0;
      try_q      <= '0;
      stuck_q    <= 1'b0;
      rd_busy_q  <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= capture_stb && rd_busy_q;  // align needs one cycle
      if (lat_q != '0) begin
        lat_q <= lat_q - 1'b1;
      end
      case (state_q)
        ST_IDLE_RESET: begin
          if (!stuck_q) begin
            state_q <= ST_TRAIN_WR;
          end
        end
        ST_TRAIN_WR: begin
          lat_q   <= CNT_W'(RD_LAT - 1);
          state_q <= ST_TRAIN_RD;
        end
        ST_TRAIN_RD: begin
          if (capture_stb) begin
            state_q <= ST_TRAIN_CHECK;
          end
        end
        ST_TRAIN_CHECK: begin
          fail_q <= fail_now;
          if (beat_q == IDX_W'(TRAIN_LEN - 1)) begin
            beat_q <= '0;
            if (fail_now == '0) begin
              state_q <= ST_READY;
            end else if (try_q == '1) begin
              // every lane has seen all four offsets
              stuck_q <= 1'b1;
              state_q <= ST_IDLE_RESET;
            end else begin
              state_q <= ST_SLIP;
            end
          end else begin
            beat_q  <= beat_q + 1'b1;
            state_q <= ST_TRAIN_WR;
          end
        end
        ST_SLIP: begin
          fail_q  <= '0;
          try_q   <= try_q + 1'b1;
          state_q <= ST_TRAIN_WR;
        end
        ST_READY: begin
          if (rd_ok) begin
            rd_busy_q <= 1'b1;
            lat_q     <= CNT_W'(RD_LAT - 1);
          end else if (capture_stb) begin
            rd_busy_q <= 1'b0;
          end
        end
        default: begin
          state_q <= ST_IDLE_RESET;
        end
      endcase
    end
  end

endmodule

//--- hw/ddr_phy_top.sv
`timescale 1ns/1ps

module ddr_phy_top #(
  parameter int LANES  = 4,
  parameter int RD_LAT = 6
) (
  input  logic                                            PCLK,
  input  logic                                            FCLK,
  input  logic                                            RESET,
  input  logic                                            wr_stb,
  input  logic [LANES*ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] wr_data,
  input  logic                                            rd_stb,
  output logic [LANES*ddr_phy_cfg_pkg::SYMS_PER_BEAT-1:0] rd_data,
  output logic                                            rd_valid,
  output logic                                            train_done,
  inout  wire  [LANES-1:0]                                pad
);

  import ddr_phy_cfg_pkg::*;
  import ddr_phy_ctl_pkg::*;

  logic                           oe_n;
  beat_dir_t                      tx_sel;
  logic [SYMS_PER_BEAT-1:0]       pattern_beat;
  logic [SYMS_PER_BEAT-1:0]       expect_beat;
  logic                           capture_stb;
  logic [LANES-1:0]               slip_pulse;
  logic [LANES-1:0]               lane_match;
  logic [LANES*SYMS_PER_BEAT-1:0] rx_beat;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [SYMS_PER_BEAT-1:0] tx_beat;

    // pattern during training, user slice afterwards
    assign tx_beat = (tx_sel == BEAT_WR) ? wr_data[i*SYMS_PER_BEAT +: SYMS_PER_BEAT]
                                         : pattern_beat;

    ddr_lane_iob u_lane (
      .PCLK       (PCLK),
      .FCLK       (FCLK),
      .RESET      (RESET),
      .oe_n       (oe_n),
      .tx_beat    (tx_beat),
      .slip_pulse (slip_pulse[i]),
      .rx_beat    (rx_beat[i*SYMS_PER_BEAT +: SYMS_PER_BEAT]),
      .pad        (pad[i])
    );
  end

  ddr_rd_align #(
    .LANES (LANES)
  ) u_align (
    .PCLK        (PCLK),
    .RESET       (RESET),
    .capture_stb (capture_stb),
    .rx_beat     (rx_beat),
    .expect_beat (expect_beat),
    .rd_data     (rd_data),
    .lane_match  (lane_match)
  );

  ddr_train_ctrl #(
    .LANES  (LANES),
    .RD_LAT (RD_LAT)
  ) u_ctrl (
    .PCLK         (PCLK),
    .RESET        (RESET),
    .wr_stb       (wr_stb),
    .rd_stb       (rd_stb),
    .lane_match   (lane_match),
    .oe_n         (oe_n),
    .tx_sel       (tx_sel),
    .pattern_beat (pattern_beat),
    .expect_beat  (expect_beat),
    .capture_stb  (capture_stb),
    .slip_pulse   (slip_pulse),
    .rd_valid     (rd_valid),
    .train_done   (train_done)
  );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic PCLK,
  output logic FCLK,
  output logic RESET
);

  // FCLK rises together with every PCLK rise
  initial begin
    PCLK = 1'b0;
    FCLK = 1'b0;
    #5;
    forever begin
      PCLK = 1'b1;
      FCLK = 1'b1;
      #2.5 FCLK = 1'b0;
      #2.5 PCLK = 1'b0;
      FCLK = 1'b1;
      #2.5 FCLK = 1'b0;
      #2.5;
    end
  end

  initial begin
    RESET = 1'b1;
    repeat (RESET_CYCLES) @(posedge PCLK);
    @(negedge PCLK);
    RESET = 1'b0;
  end

endmodule

//--- tb/ddr_pad_model.sv
`timescale 1ns/1ps

module ddr_pad_model (
  input  logic       PCLK,
  input  logic       FCLK,
  input  logic       RESET,
  input  logic       dut_oe_n,  // lane drives the cycle after this is low
  input  logic [1:0] delay,     // FCLK samples before the echo starts
  inout  wire        pad
);

  logic       oe_a;
  logic       oe_b;      // high while the lane drives the pad
  logic       has_beat;
  logic [1:0] hold_cnt;
  logic       sym0;
  logic       sym1;
  logic       val;
  logic       driving;

  always_ff @(posedge PCLK or posedge RESET) begin
    if (RESET) begin
      oe_a <= 1'b0;
      oe_b <= 1'b0;
    end else begin
      oe_a <= !dut_oe_n;
      oe_b <= oe_a;
    end
  end

  // mid-period updates keep clear of the lane's FCLK sampling
  always_ff @(negedge FCLK or posedge RESET) begin
    if (RESET) begin
      has_beat <= 1'b0;
      hold_cnt <= '0;
      sym0     <= 1'b0;
      sym1     <= 1'b0;
      val      <= 1'b0;
      driving  <= 1'b0;
    end else begin
      if (oe_b) begin
        if (PCLK) begin
          sym0 <= pad;  // first half of the PCLK cycle
        end else begin
          sym1 <= pad;
        end
        has_beat <= 1'b1;
        hold_cnt <= delay;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      driving <= has_beat && !oe_a && !oe_b && (hold_cnt == '0);
      val     <= PCLK ? sym0 : sym1;
    end
  end

  assign pad = driving ? val : 1'bz;

endmodule

//--- tb/ddr_phy_tb.sv
`timescale 1ns/1ps

module ddr_phy_tb;

  import ddr_phy_cfg_pkg::*;

  localparam int LANES    = 4;
  localparam int RD_LAT   = 6;
  localparam int W        = LANES * SYMS_PER_BEAT;
  localparam int BEAT_CYC = RD_LAT + 4;
  localparam int N_BEATS  = 11;
  localparam int TRAIN_CYC = 16 + SLIP_POS * TRAIN_LEN * BEAT_CYC;
  localparam int LIMIT_NS = 2 * (TRAIN_CYC + N_BEATS * BEAT_CYC) * 10 + 500;

  logic             PCLK;
  logic             FCLK;
  logic             RESET;
  logic             wr_stb;
  logic [W-1:0]     wr_data;
  logic             rd_stb;
  logic [W-1:0]     rd_data;
  logic             rd_valid;
  logic             train_done;
  wire  [LANES-1:0] pad;
  logic [1:0]       pad_delay [LANES];
  logic [W-1:0]     wr_log [$];
  int               rd_count;
  int               reads_expected;
  logic             done_seen;

  tb_clock_gen #(.RESET_CYCLES(16)) u_clk (.PCLK(PCLK), .FCLK(FCLK), .RESET(RESET));

  ddr_phy_top #(.LANES(LANES), .RD_LAT(RD_LAT)) dut0 (
    .PCLK(PCLK), .FCLK(FCLK), .RESET(RESET), .wr_stb(wr_stb), .wr_data(wr_data),
    .rd_stb(rd_stb), .rd_data(rd_data), .rd_valid(rd_valid), .train_done(train_done),
    .pad(pad)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_pad
    ddr_pad_model u_pad (
      .PCLK(PCLK), .FCLK(FCLK), .RESET(RESET), .dut_oe_n(dut0.oe_n),
      .delay(pad_delay[i]), .pad(pad[i])
    );
  end

  // the pads echo whatever was driven last
  function automatic logic [W-1:0] expect_rd_word();
    return wr_log[wr_log.size()-1];
  endfunction

  task automatic report_fail();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input logic [W-1:0] got, input logic [W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic write_beats(input int n);
    logic [W-1:0] d;
    for (int i = 0; i < n; i++) begin
      d       = W'($urandom());
      wr_stb  = 1'b1;
      wr_data = d;
      wr_log.push_back(d);
      @(negedge PCLK);
    end
    wr_stb = 1'b0;
    repeat (4) @(negedge PCLK);  // lets the slowest echo settle
  endtask

  // extra_at > 0 repeats rd_stb while the read is outstanding
  task automatic read_beat(input int extra_at);
    int n;
    n      = 0;
    rd_stb = 1'b1;
    do begin
      @(negedge PCLK);
      n++;
      rd_stb = (n == extra_at);
      if (n > RD_LAT + 8) begin
        $display("read never completed: no rd_valid within %0d cycles", RD_LAT + 8);
        report_fail();
      end
    end while (!rd_valid);
    rd_stb = 1'b0;
    check_count(n, RD_LAT, "read latency");
    reads_expected++;
    repeat (RD_LAT + 2) @(negedge PCLK);
    check_count(rd_count, reads_expected, "rd_valid pulses");
  endtask

  always @(negedge PCLK) begin
    if (!RESET) begin
      if (done_seen) begin
        check_flag(train_done, 1'b1, "train_done held");
      end
      done_seen <= done_seen | train_done;
      if (rd_valid) begin
        rd_count++;
        if (wr_log.size() == 0) begin
          $display("rd_valid pulsed before any write beat was issued");
          report_fail();
        end else begin
          check_word(rd_data, expect_rd_word(), "rd_data");
        end
      end
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("simulation timed out after %0d ns, training or a read never finished", LIMIT_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wr_stb         = 1'b0;
    wr_data        = '0;
    rd_stb         = 1'b0;
    rd_count       = 0;
    reads_expected = 0;
    done_seen      = 1'b0;
    void'($urandom(32'he691_dfae));
    for (int i = 0; i < LANES; i++) begin
      pad_delay[i] = 2'($urandom());
    end
    repeat (4) @(negedge PCLK);
    check_flag(train_done, 1'b0, "train_done in reset");
    check_flag(rd_valid, 1'b0, "rd_valid in reset");
    check_flag(dut0.oe_n, 1'b1, "oe_n in reset");
    check_flag(pad === 'z, 1'b1, "pads released in reset");
    @(negedge RESET);
    rd_stb = 1'b1;  // too early, must be dropped
    @(negedge PCLK);
    rd_stb = 1'b0;
    while (!train_done) @(negedge PCLK);
    check_count(rd_count, 0, "rd_valid pulses during training");
    for (int k = 0; k < 3; k++) begin
      write_beats(1);
      read_beat(0);
    end
    write_beats(3);
    read_beat(0);
    read_beat(2);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- ddr_phy.f
hw/ddr_phy_cfg_pkg.sv
hw/ddr_phy_ctl_pkg.sv
hw/ddr_lane_iob.sv
hw/ddr_rd_align.sv
hw/ddr_train_ctrl.sv
hw/ddr_phy_top.sv
tb/tb_clock_gen.sv
tb/ddr_pad_model.sv
tb/ddr_phy_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ddr_phy_tb
FLIST     ?= ddr_phy.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
